//--- fma_mantissa_add.sv
/*
  Exponent path, mantissa product, addend alignment and the wide adder
  Results are held in the middle register, captured on valid_i
  Internal exponents stay biased and a zero product takes the minimum exponent
*/
`timescale 1ns/10ps

module fma_mantissa_add
  import fma_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  fp_t        operand_a_i,
  input  fp_t        operand_b_i,
  input  fp_t        operand_c_i,
  input  logic [2:0] normal_i,
  input  logic [2:0] subnormal_i,
  input  logic [2:0] zero_i,
  input  rnd_t       rnd_mode_i,
  input  logic       special_i,
  input  fp_t        special_result_i,
  input  status_t    special_status_i,
  input  logic       valid_i,
  output sum_t       sum_o,
  output logic       effective_subtraction_o,
  output logic       final_sign_o,
  output exp_t       exponent_product_o,
  output exp_t       exponent_difference_o,
  output exp_t       tentative_exponent_o,
  output shamt_t     addend_shamt_o,
  output logic       sticky_before_add_o,
  output rnd_t       rnd_mode_o,
  output logic       special_o,
  output fp_t        special_result_o,
  output status_t    special_status_o,
  output logic       valid_o
);

  logic   eff_sub, tentative_sign;
  exp_t   exp_a, exp_b, exp_c;
  exp_t   exp_addend, exp_product, exp_diff, tent_exp;
  shamt_t addend_shamt;

  logic [PRECISION_BITS-1:0]           mant_a, mant_b, mant_c;
  logic [2*PRECISION_BITS-1:0]         product;
  sum_t                                product_shifted;
  logic [SUM_WIDTH+PRECISION_BITS-1:0] addend_wide;
  sum_t                                addend_aligned, addend_shifted;
  logic                                sticky_before_add, carry_in;
  logic [SUM_WIDTH:0]                  sum_raw, sum_neg;
  sum_t                                sum;
  logic                                final_sign;

  assign eff_sub        = operand_a_i[FP_WIDTH-1] ^ operand_b_i[FP_WIDTH-1]
                          ^ operand_c_i[FP_WIDTH-1];
  // Product sign stands until the add resolves the final sign
  assign tentative_sign = operand_a_i[FP_WIDTH-1] ^ operand_b_i[FP_WIDTH-1];

  // --------------------
  // Exponent path
  // --------------------
  assign exp_a = exp_t'(operand_a_i[FP_WIDTH-2 -: EXP_BITS]);
  assign exp_b = exp_t'(operand_b_i[FP_WIDTH-2 -: EXP_BITS]);
  assign exp_c = exp_t'(operand_c_i[FP_WIDTH-2 -: EXP_BITS]);

  // Subnormals and zeros sit at encoded exponent 1
  assign exp_addend  = exp_c + exp_t'(!normal_i[2]);
  assign exp_product = (zero_i[0] || zero_i[1])
                       ? exp_t'(2) - exp_t'(BIAS)
                       : exp_a + exp_t'(subnormal_i[0]) + exp_b + exp_t'(subnormal_i[1])
                         - exp_t'(BIAS);
  assign exp_diff    = exp_addend - exp_product;
  assign tent_exp    = (exp_diff > 0) ? exp_addend : exp_product;

  // Saturated right shift of the addend
  always_comb begin
    if (exp_diff <= -exp_t'(2 * PRECISION_BITS + 1)) begin
      // Addend lands entirely in the sticky bit
      addend_shamt = shamt_t'(SUM_WIDTH);
    end else if (exp_diff <= exp_t'(PRECISION_BITS + 2)) begin
      addend_shamt = shamt_t'(exp_t'(PRECISION_BITS + 3) - exp_diff);
    end else begin
      // Product only reaches the sticky region
      addend_shamt = '0;
    end
  end

  // --------------------
  // Product and addend
  // --------------------
  assign mant_a  = {normal_i[0], operand_a_i[MAN_BITS-1:0]};
  assign mant_b  = {normal_i[1], operand_b_i[MAN_BITS-1:0]};
  assign mant_c  = {normal_i[2], operand_c_i[MAN_BITS-1:0]};
  assign product = mant_a * mant_b;

  // Two spare bits below the product for round and sticky
  assign product_shifted = sum_t'(product) << 2;

  // Bits pushed below the sum window are only kept as sticky
  assign addend_wide       = {mant_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign addend_aligned    = addend_wide[SUM_WIDTH+PRECISION_BITS-1 -: SUM_WIDTH];
  assign sticky_before_add = |addend_wide[PRECISION_BITS-1:0];

  // Two's complement subtract where nonzero sticky bits absorb the carry-in
  assign addend_shifted = eff_sub ? ~addend_aligned : addend_aligned;
  assign carry_in       = eff_sub & ~sticky_before_add;

  // --------------------
  // Wide adder
  // --------------------
  assign sum_raw = product_shifted + addend_shifted + carry_in;
  assign sum_neg = -sum_raw;
  // No carry on a subtraction means the sum went negative
  assign sum     = (eff_sub && !sum_raw[SUM_WIDTH]) ? sum_neg[SUM_WIDTH-1:0]
                                                    : sum_raw[SUM_WIDTH-1:0];
  assign final_sign = eff_sub ? (sum_raw[SUM_WIDTH] == tentative_sign) : tentative_sign;

  // Middle register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      sum_o                   <= sum;
      effective_subtraction_o <= eff_sub;
      final_sign_o            <= final_sign;
      exponent_product_o      <= exp_product;
      exponent_difference_o   <= exp_diff;
      tentative_exponent_o    <= tent_exp;
      addend_shamt_o          <= addend_shamt;
      sticky_before_add_o     <= sticky_before_add;
      rnd_mode_o              <= rnd_mode_i;
      special_o               <= special_i;
      special_result_o        <= special_result_i;
      special_status_o        <= special_status_i;
    end
  end

endmodule

//--- fma_normalize.sv
/*
  Normalization of the wide sum, purely combinational
  Output mantissa carries the implicit bit on top and the round bit at bit 0
  A zero final exponent marks a subnormal or zero result
*/
`timescale 1ns/10ps

module fma_normalize
  import fma_pkg::*;
(
  input  sum_t                    sum_i,
  input  logic                    effective_subtraction_i,
  input  exp_t                    exponent_product_i,
  input  exp_t                    exponent_difference_i,
  input  exp_t                    tentative_exponent_i,
  input  shamt_t                  addend_shamt_i,
  input  logic                    sticky_before_add_i,
  output logic [PRECISION_BITS:0] final_mantissa_o,
  output exp_t                    final_exponent_o,
  output logic                    sticky_after_norm_o,
  output logic                    tie_sticky_o
);

  logic [LOWER_SUM_WIDTH-1:0] sum_lower;
  shamt_t                     lzc;
  logic                       lzc_zeroes;
  exp_t                       lzc_exponent;
  shamt_t                     norm_shamt;
  exp_t                       normalized_exponent;
  logic [SUM_WIDTH:0]         sum_ext, sum_shifted;
  logic [LOWER_SUM_WIDTH-1:0] sum_sticky_bits;

  // --------------------
  // Leading-zero count
  // --------------------
  assign sum_lower = sum_i[LOWER_SUM_WIDTH-1:0];

  always_comb begin
    lzc        = '0;
    lzc_zeroes = 1'b1;
    for (int i = LOWER_SUM_WIDTH - 1; i >= 0; i--) begin
      if (lzc_zeroes) begin
        if (sum_lower[i]) begin
          lzc_zeroes = 1'b0;
        end else begin
          lzc = lzc + 1'b1;
        end
      end
    end
  end

  // Exponent if all counted zeros are removed
  assign lzc_exponent = exponent_product_i - exp_t'(lzc) + exp_t'(1);

  // Large shift amount
  always_comb begin
    if ((exponent_difference_i <= 0)
        || (effective_subtraction_i && (exponent_difference_i <= 2))) begin
      // Product-anchored or cancelling, LZC decides
      if ((lzc_exponent >= 0) && !lzc_zeroes) begin
        norm_shamt          = shamt_t'(PRECISION_BITS + 2) + lzc;
        normalized_exponent = lzc_exponent;
      end else begin
        // Stop at the subnormal boundary
        norm_shamt          = shamt_t'(exp_t'(PRECISION_BITS + 2) + exponent_product_i);
        normalized_exponent = '0;
      end
    end else begin
      // Addend-anchored, undo the alignment shift
      norm_shamt          = addend_shamt_i;
      normalized_exponent = tentative_exponent_i;
    end
  end

  assign sum_ext     = {1'b0, sum_i};
  assign sum_shifted = sum_ext << norm_shamt;

  // --------------------
  // One-bit correction
  // --------------------
  always_comb begin
    {final_mantissa_o, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exponent_o                    = normalized_exponent;
    if (sum_shifted[SUM_WIDTH]) begin
      // Carry out, shift right and keep the dropped bit as sticky
      {final_mantissa_o, sum_sticky_bits} = {sum_shifted[SUM_WIDTH:2], |sum_shifted[1:0]};
      final_exponent_o                    = normalized_exponent + exp_t'(1);
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      // Already normalized
      final_exponent_o = normalized_exponent;
    end else if (normalized_exponent > 1) begin
      {final_mantissa_o, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exponent_o                    = normalized_exponent - exp_t'(1);
    end else begin
      final_exponent_o = '0;
    end
  end

  assign sticky_after_norm_o = (|sum_sticky_bits) | sticky_before_add_i;
  // First bit below the round bit, tells a true halfway case apart
  assign tie_sticky_o        = sum_sticky_bits[LOWER_SUM_WIDTH-1];

endmodule

//--- fma_operand_prep.sv
/*
  Input stage of the FMA: request register, operand adjustment,
  classification and special-case result
  Data is captured only on in_valid_i, outputs follow one cycle later
  Classification bits are ordered A, B, C from bit 0 up
*/
`timescale 1ns/10ps

module fma_operand_prep
  import fma_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       in_valid_i,
  input  fp_t        operand_a_i,
  input  fp_t        operand_b_i,
  input  fp_t        operand_c_i,
  input  op_t        op_i,
  input  logic       op_mod_i,
  input  rnd_t       rnd_mode_i,
  output fp_t        operand_a_o,
  output fp_t        operand_b_o,
  output fp_t        operand_c_o,
  output logic [2:0] normal_o,
  output logic [2:0] subnormal_o,
  output logic [2:0] zero_o,
  output rnd_t       rnd_mode_o,
  output logic       special_o,
  output fp_t        special_result_o,
  output status_t    special_status_o,
  output logic       valid_o
);

  logic valid_q;
  fp_t  a_q, b_q, c_q;
  op_t  op_q;
  logic op_mod_q;
  rnd_t rnd_q;

  fp_t        opnd [3];
  logic [2:0] is_inf, is_nan, is_snan;
  logic       eff_sub;

  // --------------------
  // Request register
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      a_q      <= operand_a_i;
      b_q      <= operand_b_i;
      c_q      <= operand_c_i;
      op_q     <= op_i;
      op_mod_q <= op_mod_i;
      rnd_q    <= rnd_mode_i;
    end
  end

  // --------------------
  // Operation adjustment
  // --------------------
  always_comb begin
    opnd[0] = a_q;
    opnd[1] = b_q;
    opnd[2] = c_q;
    // Modifier always negates the addend
    opnd[2][FP_WIDTH-1] = c_q[FP_WIDTH-1] ^ op_mod_q;
    case (op_q)
      OP_FMADD:  ;
      OP_FNMSUB: opnd[0][FP_WIDTH-1] = ~a_q[FP_WIDTH-1];
      // Multiplicand becomes +1.0
      OP_ADD:    opnd[0] = {1'b0, EXP_BITS'(BIAS), {MAN_BITS{1'b0}}};
      // Addend becomes a zero that keeps the product sign of zero results
      OP_MUL:    opnd[2] = {rnd_q != RDN, {(FP_WIDTH-1){1'b0}}};
    endcase
  end

  // Classification per operand
  for (genvar i = 0; i < 3; i++) begin : gen_class
    logic exp_ones, exp_zero, man_zero;
    assign exp_ones       = &opnd[i][FP_WIDTH-2 -: EXP_BITS];
    assign exp_zero       = ~|opnd[i][FP_WIDTH-2 -: EXP_BITS];
    assign man_zero       = ~|opnd[i][MAN_BITS-1:0];
    assign zero_o[i]      = exp_zero & man_zero;
    assign subnormal_o[i] = exp_zero & ~man_zero;
    assign normal_o[i]    = ~exp_zero & ~exp_ones;
    assign is_inf[i]      = exp_ones & man_zero;
    assign is_nan[i]      = exp_ones & ~man_zero;
    // Quiet bit is the mantissa MSB
    assign is_snan[i]     = is_nan[i] & ~opnd[i][MAN_BITS-1];
  end

  assign eff_sub = opnd[0][FP_WIDTH-1] ^ opnd[1][FP_WIDTH-1] ^ opnd[2][FP_WIDTH-1];

  // --------------------
  // Special cases
  // --------------------
  // Priority: inf times zero, any NaN, then infinities
  always_comb begin
    special_result_o = QNAN;
    special_status_o = '0;
    special_o        = 1'b0;
    if ((is_inf[0] && zero_o[1]) || (zero_o[0] && is_inf[1])) begin
      // Invalid even with a quiet NaN addend
      special_o               = 1'b1;
      special_status_o[ST_NV] = 1'b1;
    end else if (|is_nan) begin
      special_o               = 1'b1;
      special_status_o[ST_NV] = |is_snan;
    end else if (|is_inf) begin
      special_o = 1'b1;
      if ((is_inf[0] || is_inf[1]) && is_inf[2] && eff_sub) begin
        special_status_o[ST_NV] = 1'b1;
      end else if (is_inf[0] || is_inf[1]) begin
        // Infinity with the product sign
        special_result_o = {opnd[0][FP_WIDTH-1] ^ opnd[1][FP_WIDTH-1],
                            {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end else begin
        special_result_o = {opnd[2][FP_WIDTH-1], {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}};
      end
    end
  end

  assign operand_a_o = opnd[0];
  assign operand_b_o = opnd[1];
  assign operand_c_o = opnd[2];
  assign rnd_mode_o  = rnd_q;
  assign valid_o     = valid_q;

endmodule

//--- fma_pkg.sv
/*
  Shared constants and types for the binary16 FMA unit
  The format is fixed, widths are derived from EXP_BITS and MAN_BITS
  Status flags are ordered NV, DZ, OF, UF, NX from the MSB down
*/
package fma_pkg;

  // Format
  localparam int unsigned EXP_BITS = 5;
  localparam int unsigned MAN_BITS = 10;
  localparam int unsigned BIAS     = 15;
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;

  // Derived datapath widths
  localparam int unsigned PRECISION_BITS     = MAN_BITS + 1;
  // Lower 2p+3 bits of the sum are searched for leading zeros
  localparam int unsigned LOWER_SUM_WIDTH    = 2 * PRECISION_BITS + 3;
  // Wide enough for every meaningful exponent, also covers the LZC count
  localparam int unsigned EXP_WIDTH          = EXP_BITS + 2;
  localparam int unsigned SHIFT_AMOUNT_WIDTH = $clog2(3 * PRECISION_BITS + 5);
  localparam int unsigned SUM_WIDTH          = 3 * PRECISION_BITS + 4;

  // Status bit positions
  localparam int unsigned ST_NV = 4;
  localparam int unsigned ST_DZ = 3;
  localparam int unsigned ST_OF = 2;
  localparam int unsigned ST_UF = 1;
  localparam int unsigned ST_NX = 0;

  typedef logic        [FP_WIDTH-1:0]           fp_t;
  typedef logic signed [EXP_WIDTH-1:0]          exp_t;
  typedef logic        [SHIFT_AMOUNT_WIDTH-1:0] shamt_t;
  typedef logic        [SUM_WIDTH-1:0]          sum_t;
  typedef logic        [4:0]                    status_t;
  typedef logic        [1:0]                    op_t;
  typedef logic        [2:0]                    rnd_t;

  // Operation codes, op_mod negates the addend on top of these
  localparam op_t OP_FMADD  = 2'd0;
  localparam op_t OP_FNMSUB = 2'd1;
  localparam op_t OP_ADD    = 2'd2;
  localparam op_t OP_MUL    = 2'd3;

  // Rounding modes
  localparam rnd_t RNE = 3'd0;
  localparam rnd_t RTZ = 3'd1;
  localparam rnd_t RDN = 3'd2;
  localparam rnd_t RUP = 3'd3;
  localparam rnd_t RMM = 3'd4;

  // Canonical quiet NaN
  localparam fp_t QNAN = 16'h7E00;

endpackage

//--- fma_round.sv
/*
  Rounding, status flags and output register
  Pre-round overflow saturates to the largest normal before rounding
  Underflow is detected after rounding and only raised when inexact
*/
`timescale 1ns/10ps

module fma_round
  import fma_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [PRECISION_BITS:0] final_mantissa_i,
  input  exp_t                    final_exponent_i,
  input  logic                    sticky_after_norm_i,
  input  logic                    tie_sticky_i,
  input  logic                    final_sign_i,
  input  logic                    effective_subtraction_i,
  input  rnd_t                    rnd_mode_i,
  input  logic                    special_i,
  input  fp_t                     special_result_i,
  input  status_t                 special_status_i,
  input  logic                    valid_i,
  output fp_t                     result_o,
  output status_t                 status_o,
  output logic                    out_valid_o
);

  logic                         of_before_round, of_after_round, uf_after_round;
  logic [EXP_BITS-1:0]          pre_round_exponent;
  logic [MAN_BITS-1:0]          pre_round_mantissa;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs, rounded_abs;
  logic [1:0]                   round_sticky_bits;
  logic                         round_up, result_zero, rounded_sign;
  logic                         inexact;
  fp_t                          regular_result;
  status_t                      regular_status;

  // --------------------
  // Pre-round assembly
  // --------------------
  assign of_before_round    = final_exponent_i >= exp_t'(2**EXP_BITS - 1);
  assign pre_round_exponent = of_before_round ? EXP_BITS'(2**EXP_BITS - 2)
                                              : final_exponent_i[EXP_BITS-1:0];
  assign pre_round_mantissa = of_before_round ? '1 : final_mantissa_i[MAN_BITS:1];
  assign pre_round_abs      = {pre_round_exponent, pre_round_mantissa};
  // Forced round and sticky so overflow rounds by mode
  assign round_sticky_bits  = of_before_round ? 2'b11
                                              : {final_mantissa_i[0], sticky_after_norm_i};

  always_comb begin
    case (rnd_mode_i)
      RNE:     round_up = round_sticky_bits[1] & (round_sticky_bits[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky_bits) & final_sign_i;
      RUP:     round_up = (|round_sticky_bits) & ~final_sign_i;
      RMM:     round_up = round_sticky_bits[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent
  assign rounded_abs  = pre_round_abs + round_up;
  assign result_zero  = (pre_round_abs == '0) && (round_sticky_bits == 2'b00);
  // Exact cancellation gives +0, -0 only when rounding down
  assign rounded_sign = (result_zero && effective_subtraction_i) ? (rnd_mode_i == RDN)
                                                                 : final_sign_i;

  // --------------------
  // Flags
  // --------------------
  assign uf_after_round = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0)
      || ((pre_round_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0)
          && (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == EXP_BITS'(1))
          && ((round_sticky_bits != 2'b11)
              || (!tie_sticky_i && ((rnd_mode_i == RNE) || (rnd_mode_i == RMM)))));
  assign of_after_round = &rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];
  assign inexact        = (|round_sticky_bits) | of_before_round | of_after_round;

  assign regular_result        = {rounded_sign, rounded_abs};
  assign regular_status[ST_NV] = 1'b0;
  assign regular_status[ST_DZ] = 1'b0;
  assign regular_status[ST_OF] = of_before_round | of_after_round;
  assign regular_status[ST_UF] = uf_after_round & inexact;
  assign regular_status[ST_NX] = inexact;

  // Output register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= special_i ? special_result_i : regular_result;
      status_o <= special_i ? special_status_i : regular_status;
    end
  end

endmodule

//--- fma_top.sv
/*
  Pipelined binary16 fused multiply-add, three register stages
  A valid item may enter every cycle, there is no back-pressure
  out_valid_o marks each result for a single cycle, in arrival order
*/
`timescale 1ns/10ps

module fma_top
  import fma_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    in_valid_i,
  input  fp_t     operand_a_i,
  input  fp_t     operand_b_i,
  input  fp_t     operand_c_i,
  input  op_t     op_i,
  input  logic    op_mod_i,
  input  rnd_t    rnd_mode_i,
  output fp_t     result_o,
  output status_t status_o,
  output logic    out_valid_o
);

  // Input side
  fp_t        prep_a, prep_b, prep_c;
  logic [2:0] prep_normal, prep_subnormal, prep_zero;
  rnd_t       prep_rnd;
  logic       prep_special, prep_valid;
  fp_t        prep_special_result;
  status_t    prep_special_status;

  // Middle register
  sum_t    mid_sum;
  logic    mid_eff_sub, mid_final_sign, mid_sticky;
  exp_t    mid_exp_product, mid_exp_diff, mid_tent_exp;
  shamt_t  mid_shamt;
  rnd_t    mid_rnd;
  logic    mid_special, mid_valid;
  fp_t     mid_special_result;
  status_t mid_special_status;

  // Normalized value
  logic [PRECISION_BITS:0] norm_mantissa;
  exp_t                    norm_exponent;
  logic                    norm_sticky, norm_tie;

  fma_operand_prep u_prep (
    .clk_i, .reset_i, .in_valid_i, .operand_a_i, .operand_b_i, .operand_c_i,
    .op_i, .op_mod_i, .rnd_mode_i,
    .operand_a_o      (prep_a),
    .operand_b_o      (prep_b),
    .operand_c_o      (prep_c),
    .normal_o         (prep_normal),
    .subnormal_o      (prep_subnormal),
    .zero_o           (prep_zero),
    .rnd_mode_o       (prep_rnd),
    .special_o        (prep_special),
    .special_result_o (prep_special_result),
    .special_status_o (prep_special_status),
    .valid_o          (prep_valid)
  );

  fma_mantissa_add u_add (
    .clk_i, .reset_i,
    .operand_a_i             (prep_a),
    .operand_b_i             (prep_b),
    .operand_c_i             (prep_c),
    .normal_i                (prep_normal),
    .subnormal_i             (prep_subnormal),
    .zero_i                  (prep_zero),
    .rnd_mode_i              (prep_rnd),
    .special_i               (prep_special),
    .special_result_i        (prep_special_result),
    .special_status_i        (prep_special_status),
    .valid_i                 (prep_valid),
    .sum_o                   (mid_sum),
    .effective_subtraction_o (mid_eff_sub),
    .final_sign_o            (mid_final_sign),
    .exponent_product_o      (mid_exp_product),
    .exponent_difference_o   (mid_exp_diff),
    .tentative_exponent_o    (mid_tent_exp),
    .addend_shamt_o          (mid_shamt),
    .sticky_before_add_o     (mid_sticky),
    .rnd_mode_o              (mid_rnd),
    .special_o               (mid_special),
    .special_result_o        (mid_special_result),
    .special_status_o        (mid_special_status),
    .valid_o                 (mid_valid)
  );

  fma_normalize u_norm (
    .sum_i                   (mid_sum),
    .effective_subtraction_i (mid_eff_sub),
    .exponent_product_i      (mid_exp_product),
    .exponent_difference_i   (mid_exp_diff),
    .tentative_exponent_i    (mid_tent_exp),
    .addend_shamt_i          (mid_shamt),
    .sticky_before_add_i     (mid_sticky),
    .final_mantissa_o        (norm_mantissa),
    .final_exponent_o        (norm_exponent),
    .sticky_after_norm_o     (norm_sticky),
    .tie_sticky_o            (norm_tie)
  );

  fma_round u_round (
    .clk_i, .reset_i,
    .final_mantissa_i        (norm_mantissa),
    .final_exponent_i        (norm_exponent),
    .sticky_after_norm_i     (norm_sticky),
    .tie_sticky_i            (norm_tie),
    .final_sign_i            (mid_final_sign),
    .effective_subtraction_i (mid_eff_sub),
    .rnd_mode_i              (mid_rnd),
    .special_i               (mid_special),
    .special_result_i        (mid_special_result),
    .special_status_i        (mid_special_status),
    .valid_i                 (mid_valid),
    .result_o, .status_o, .out_valid_o
  );

endmodule

//--- list.f
fma_pkg.sv
fma_operand_prep.sv
fma_mantissa_add.sv
fma_normalize.sv
fma_round.sv
fma_top.sv
tb_fma.sv

//--- run.sh
#!/bin/sh
# Build the FMA testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_fma -o tb_fma > build.log 2>&1 &&
./obj_dir/tb_fma > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "Simulation passed" || { echo "Checks failed"; exit 1; }

//--- tb_fma.sv
/*
  Table-driven testbench for the binary16 FMA pipeline
  Expected values are precomputed binary16 encodings and status flags
  Inputs change on the falling edge, outputs are checked on the falling edge
  An item's result must show three rising edges after the item is driven
*/
`timescale 1ns/10ps

module tb_fma
  import fma_pkg::*;
();

  typedef struct {
    string   name;
    fp_t     a;
    fp_t     b;
    fp_t     c;
    op_t     op;
    logic    op_mod;
    rnd_t    rnd;
    fp_t     exp_result;
    status_t exp_status;
  } test_t;

  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = 3;

  // Flag sets, NV DZ OF UF NX from the MSB
  localparam status_t FL_NONE = 5'b00000;
  localparam status_t FL_NV   = 5'b10000;
  localparam status_t FL_NX   = 5'b00001;
  localparam status_t FL_OFX  = 5'b00101;
  localparam status_t FL_UFX  = 5'b00011;

  logic    clk_i;
  logic    reset_i;
  logic    in_valid_i;
  fp_t     operand_a_i;
  fp_t     operand_b_i;
  fp_t     operand_c_i;
  op_t     op_i;
  logic    op_mod_i;
  rnd_t    rnd_mode_i;
  fp_t     result_o;
  status_t status_o;
  logic    out_valid_o;

  test_t  tests[$];
  // Items in flight, index into the table and the cycle they were driven
  int     pend_idx[$];
  int     pend_cycle[$];
  int     cycle_count    = 0;
  int     timeout_cycles = 0;
  int     error_count    = 0;
  int     done_count     = 0;
  int     fail_count     = 0;
  integer seed           = 32'hf0ec1053;

  fma_top DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o)
  );

  // 20 ns clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string sig_name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s got %0h expected %0h", $time, sig_name, actual, expected);
      error_count++;
    end
  endtask

  task automatic add_test(input string name, input fp_t a, input fp_t b, input fp_t c,
                          input op_t op, input logic op_mod, input rnd_t rnd,
                          input fp_t exp_result, input status_t exp_status);
    test_t t;
    t = '{name, a, b, c, op, op_mod, rnd, exp_result, exp_status};
    tests.push_back(t);
  endtask

  task automatic build_table();
    // Exact results, 1.5 x 2.0 and 0.5 in all sign variants
    add_test("fmadd", 16'h3E00, 16'h4000, 16'h3800, OP_FMADD, 1'b0, RNE, 16'h4300, FL_NONE);
    add_test("fmsub", 16'h3E00, 16'h4000, 16'h3800, OP_FMADD, 1'b1, RNE, 16'h4100, FL_NONE);
    add_test("fnmsub", 16'h3E00, 16'h4000, 16'h3800, OP_FNMSUB, 1'b0, RNE, 16'hC100, FL_NONE);
    add_test("fnmadd", 16'h3E00, 16'h4000, 16'h3800, OP_FNMSUB, 1'b1, RNE, 16'hC300, FL_NONE);
    // A is a junk value, ignored by ADD and SUB
    add_test("add", 16'h5555, 16'h3E00, 16'h3800, OP_ADD, 1'b0, RNE, 16'h4000, FL_NONE);
    add_test("sub", 16'h5555, 16'h3E00, 16'h3800, OP_ADD, 1'b1, RNE, 16'h3C00, FL_NONE);
    // C is ignored by MUL
    add_test("mul", 16'h3E00, 16'h4000, 16'h4400, OP_MUL, 1'b0, RNE, 16'h4200, FL_NONE);
    add_test("mul_neg0", 16'h4000, 16'h8000, 16'h3C00, OP_MUL, 1'b0, RNE, 16'h8000, FL_NONE);
    add_test("mul_rdn0", 16'h0000, 16'h0000, 16'h3C00, OP_MUL, 1'b0, RDN, 16'h0000, FL_NONE);
    // 1 + 2^-11 + 2^-20, just above the halfway point
    add_test("rne_pos", 16'h3C02, 16'h1000, 16'h3C00, OP_FMADD, 1'b0, RNE, 16'h3C01, FL_NX);
    add_test("rtz_pos", 16'h3C02, 16'h1000, 16'h3C00, OP_FMADD, 1'b0, RTZ, 16'h3C00, FL_NX);
    add_test("rdn_pos", 16'h3C02, 16'h1000, 16'h3C00, OP_FMADD, 1'b0, RDN, 16'h3C00, FL_NX);
    add_test("rup_pos", 16'h3C02, 16'h1000, 16'h3C00, OP_FMADD, 1'b0, RUP, 16'h3C01, FL_NX);
    add_test("rmm_pos", 16'h3C02, 16'h1000, 16'h3C00, OP_FMADD, 1'b0, RMM, 16'h3C01, FL_NX);
    // Same magnitude negated through FNMADD
    add_test("rne_neg", 16'h3C02, 16'h1000, 16'h3C00, OP_FNMSUB, 1'b1, RNE, 16'hBC01, FL_NX);
    add_test("rtz_neg", 16'h3C02, 16'h1000, 16'h3C00, OP_FNMSUB, 1'b1, RTZ, 16'hBC00, FL_NX);
    add_test("rdn_neg", 16'h3C02, 16'h1000, 16'h3C00, OP_FNMSUB, 1'b1, RDN, 16'hBC01, FL_NX);
    add_test("rup_neg", 16'h3C02, 16'h1000, 16'h3C00, OP_FNMSUB, 1'b1, RUP, 16'hBC00, FL_NX);
    add_test("rmm_neg", 16'h3C02, 16'h1000, 16'h3C00, OP_FNMSUB, 1'b1, RMM, 16'hBC01, FL_NX);
    // Special cases
    add_test("inf_x_zero", 16'h7C00, 16'h0000, 16'h7E00, OP_FMADD, 1'b0, RNE, QNAN, FL_NV);
    add_test("snan_in", 16'h7C01, 16'h3C00, 16'h3C00, OP_FMADD, 1'b0, RNE, QNAN, FL_NV);
    add_test("qnan_in", 16'h3C00, 16'h7E00, 16'h3C00, OP_FMADD, 1'b0, RNE, QNAN, FL_NONE);
    add_test("inf_m_inf", 16'h7C00, 16'h3C00, 16'h7C00, OP_FMADD, 1'b1, RNE, QNAN, FL_NV);
    add_test("inf_prod", 16'hFC00, 16'h4000, 16'h3C00, OP_FMADD, 1'b0, RNE, 16'hFC00, FL_NONE);
    add_test("inf_addend", 16'h3C00, 16'h3C00, 16'hFC00, OP_FMADD, 1'b0, RNE, 16'hFC00, FL_NONE);
    // 256 x 512 is beyond the largest normal
    add_test("ovf_rne", 16'h5C00, 16'h6000, 16'h0000, OP_FMADD, 1'b0, RNE, 16'h7C00, FL_OFX);
    add_test("ovf_rtz", 16'h5C00, 16'h6000, 16'h0000, OP_FMADD, 1'b0, RTZ, 16'h7BFF, FL_OFX);
    // 513 + 2^-11 subnormal units, then exactly 512 units
    add_test("tiny_inexact", 16'h0401, 16'h3801, 16'h0000, OP_FMADD, 1'b0, RNE, 16'h0201, FL_UFX);
    add_test("tiny_exact", 16'h0400, 16'h3800, 16'h0000, OP_FMADD, 1'b0, RNE, 16'h0200, FL_NONE);
    // 1 x 1 - 1
    add_test("cancel_rne", 16'h3C00, 16'h3C00, 16'h3C00, OP_FMADD, 1'b1, RNE, 16'h0000, FL_NONE);
    add_test("cancel_rdn", 16'h3C00, 16'h3C00, 16'h3C00, OP_FMADD, 1'b1, RDN, 16'h8000, FL_NONE);
  endtask

  task automatic apply_test(input int idx);
    operand_a_i = tests[idx].a;
    operand_b_i = tests[idx].b;
    operand_c_i = tests[idx].c;
    op_i        = tests[idx].op;
    op_mod_i    = tests[idx].op_mod;
    rnd_mode_i  = tests[idx].rnd;
    in_valid_i  = 1'b1;
    pend_idx.push_back(idx);
    pend_cycle.push_back(cycle_count);
  endtask

  // --------------------
  // Cycle counter and timeout
  // --------------------
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if ((timeout_cycles > 0) && (cycle_count >= timeout_cycles)) begin
      $display("Timeout at cycle %0d, %0d of %0d results never appeared",
               cycle_count, tests.size() - done_count, tests.size());
      $display("Checks failed");
      $finish;
    end
  end

  // --------------------
  // Output monitor
  // --------------------
  always @(negedge clk_i) begin
    int idx;
    int issued;
    int errors_before;
    if (pend_idx.size() == 0) begin
      // Covers the reset period and any stray result
      if (out_valid_o !== 1'b0) begin
        $display("At %0t out_valid_o is not low while no item is in flight", $time);
        error_count++;
      end
    end else if (out_valid_o === 1'b1) begin
      idx           = pend_idx.pop_front();
      issued        = pend_cycle.pop_front();
      errors_before = error_count;
      check_value("result_o", 32'(result_o), 32'(tests[idx].exp_result));
      check_value("status_o", 32'(status_o), 32'(tests[idx].exp_status));
      check_value("latency", 32'(cycle_count - issued), 32'(LATENCY));
      done_count++;
      if (error_count == errors_before) begin
        $display("test %2d %-12s pass", idx, tests[idx].name);
      end else begin
        fail_count++;
        $display("test %2d %-12s FAIL", idx, tests[idx].name);
      end
    end else if (cycle_count >= pend_cycle[0] + LATENCY) begin
      // Expected slot passed without a result
      idx    = pend_idx.pop_front();
      issued = pend_cycle.pop_front();
      $display("At %0t no result appeared for test %0d %s", $time, idx, tests[idx].name);
      error_count++;
      fail_count++;
      done_count++;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int gap;
    reset_i     = 1'b1;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i        = OP_FMADD;
    op_mod_i    = 1'b0;
    rnd_mode_i  = RNE;
    build_table();
    // Reset, worst-case gaps and pipeline drain with margin
    timeout_cycles = RESET_CYCLES + 4 * tests.size() + 20;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    foreach (tests[i]) begin
      apply_test(i);
      @(negedge clk_i);
      in_valid_i = 1'b0;
      // Zero gap keeps in_valid_i high into the next entry
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge clk_i);
    end
    while (done_count < tests.size()) begin
      @(negedge clk_i);
    end
    // A few idle cycles to catch a late or extra out_valid_o
    repeat (LATENCY + 1) @(negedge clk_i);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests.size(), done_count - fail_count, fail_count, error_count);
    if ((error_count == 0) && (fail_count == 0)) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
